//--- hw/tile_arb_pkg.sv
// tile write arbiter shared definitions
// vector types for the SRAM port and tile geometry, the execute FSM
// encoding and the default screen layout
`default_nettype none

package tile_arb_pkg;

	// ------------------------------------------------------------
	// vector types
	// ------------------------------------------------------------
	typedef logic [31:0] pix_addr_t;  // SRAM byte address of one pixel
	typedef logic [7:0]  color_t;     // 8-bit pixel colour
	typedef logic [9:0]  band_t;      // row of tiles on the screen
	typedef logic [7:0]  coord_t;     // x or y inside one tile

	// execute FSM
	typedef enum logic [1:0] {
		ST_START,  // one-shot start pulse after reset
		ST_IDLE,   // waiting for a request
		ST_WRITE,  // one pixel per clock
		ST_DONE    // gap cycle while done goes out
	} exec_state_t;

	// ------------------------------------------------------------
	// default geometry
	// ------------------------------------------------------------
	parameter int DEF_NUM_REQ   = 64;   // tile engines
	parameter int DEF_TILE_SIZE = 7;    // pixels per tile side
	parameter int DEF_SCREEN_W  = 640;  // pixels per screen line

endpackage

`default_nettype wire

//--- hw/tile_req_decode.sv
// tile request decode
// lowest-index priority select over the engine request lines
`timescale 1ns/1ps
`default_nettype none

module tile_req_decode
	import tile_arb_pkg::*;
#(
	parameter int  NUM_REQ = DEF_NUM_REQ,
	localparam int IDX_W   = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1
) (
	input  wire logic [NUM_REQ-1:0] req,
	output logic                    req_valid,
	output logic [IDX_W-1:0]        req_idx
);

	// ------------------------------------------------------------
	// priority encoder
	// ------------------------------------------------------------
	assign req_valid = |req;

	// walk from the top down so the lowest set bit is written last
	always_comb begin
		req_idx = '0;
		for (int i = NUM_REQ - 1; i >= 0; i--) begin
			if (req[i]) begin
				req_idx = IDX_W'(i);
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/tile_walk_exec.sv
// tile walk execute stage
// grants one engine, walks its tile in raster order at one pixel per
// clock and drives the registered SRAM write port
`timescale 1ns/1ps
`default_nettype none

module tile_walk_exec
	import tile_arb_pkg::*;
#(
	parameter int  NUM_REQ   = DEF_NUM_REQ,
	parameter int  TILE_SIZE = DEF_TILE_SIZE,
	parameter int  SCREEN_W  = DEF_SCREEN_W,
	localparam int IDX_W     = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1
) (
	input  wire logic             clk,
	input  wire logic             arst_n,
	input  wire logic             req_valid,
	input  wire logic [IDX_W-1:0] req_idx,
	input  wire band_t            band,
	input  wire color_t           pxl_clr,
	output logic                  start,
	output pix_addr_t             sram_addr,
	output color_t                sram_wdata,
	output logic                  sram_wr,
	output logic                  tile_end,
	output logic [IDX_W-1:0]      tile_idx
);

	localparam coord_t LAST = coord_t'(TILE_SIZE - 1);

	exec_state_t      state;
	band_t            band_q;    // band latched at grant
	coord_t           col, row;  // pixel currently on the SRAM port
	coord_t           col_nxt, row_nxt;
	logic [IDX_W-1:0] idx_sel;
	band_t            band_sel;
	logic             last_pix;
	logic             grant;
	logic             launch;    // a pixel goes out next cycle

	// tile origin plus offset, in screen pixels
	function automatic pix_addr_t pix_addr(input logic [IDX_W-1:0] idx, input band_t bnd,
	                                       input coord_t c, input coord_t r);
		pix_addr_t x_pix;
		pix_addr_t y_pix;
		x_pix = pix_addr_t'(idx) * TILE_SIZE + pix_addr_t'(c);
		y_pix = pix_addr_t'(bnd) * TILE_SIZE + pix_addr_t'(r);
		return x_pix + y_pix * SCREEN_W;
	endfunction

	// ------------------------------------------------------------
	// next pixel
	// ------------------------------------------------------------
	assign last_pix = (col == LAST) && (row == LAST);
	assign tile_end = (state == ST_WRITE) && last_pix;
	assign grant    = (state == ST_IDLE) && req_valid;
	assign launch   = grant || ((state == ST_WRITE) && !last_pix);

	// on a grant the latched copies are not loaded yet
	assign idx_sel  = (state == ST_IDLE) ? req_idx : tile_idx;
	assign band_sel = (state == ST_IDLE) ? band : band_q;

	always_comb begin
		if (state == ST_IDLE) begin
			col_nxt = '0;
			row_nxt = '0;
		end else if (col == LAST) begin  // wrap to next line
			col_nxt = '0;
			row_nxt = row + 1'b1;
		end else begin
			col_nxt = col + 1'b1;
			row_nxt = row;
		end
	end

	// ------------------------------------------------------------
	// FSM and counters
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= ST_START;
			start   <= 1'b0;
			sram_wr <= 1'b0;
			col     <= '0;
			row     <= '0;
		end else begin
			start   <= (state == ST_START);  // single pulse
			sram_wr <= launch;
			if (launch) begin
				col <= col_nxt;
				row <= row_nxt;
			end
			case (state)
				ST_START: state <= ST_IDLE;
				ST_IDLE: begin
					if (req_valid) begin
						state <= ST_WRITE;
					end
				end
				ST_WRITE: begin
					if (last_pix) begin
						state <= ST_DONE;
					end
				end
				ST_DONE: state <= ST_IDLE;  // served engine drops req here
				default: state <= ST_START;
			endcase
		end
	end

	// write payload
	always_ff @(posedge clk) begin
		if (grant) begin
			tile_idx <= req_idx;
			band_q   <= band;
		end
		if (launch) begin
			sram_addr  <= pix_addr(idx_sel, band_sel, col_nxt, row_nxt);
			sram_wdata <= pxl_clr;
		end
	end

endmodule

`default_nettype wire

//--- hw/tile_done_flags.sv
// tile done flags
// one-cycle one-hot done pulse to the engine whose tile just finished
`timescale 1ns/1ps
`default_nettype none

module tile_done_flags
	import tile_arb_pkg::*;
#(
	parameter int  NUM_REQ = DEF_NUM_REQ,
	localparam int IDX_W   = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1
) (
	input  wire logic             clk,
	input  wire logic             arst_n,
	input  wire logic             tile_end,
	input  wire logic [IDX_W-1:0] tile_idx,
	output logic [NUM_REQ-1:0]    done
);

	logic [NUM_REQ-1:0] done_nxt;

	// ------------------------------------------------------------
	// one-hot decode of the finished tile
	// ------------------------------------------------------------
	always_comb begin
		done_nxt = '0;
		if (tile_end) begin
			done_nxt[tile_idx] = 1'b1;
		end
	end

	// cleared again on the next edge unless another tile ends
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			done <= '0;
		end else begin
			done <= done_nxt;
		end
	end

endmodule

`default_nettype wire

//--- hw/tile_arbiter.sv
// tile write arbiter top level
// engines request a tile, the arbiter writes it pixel by pixel into
// the VGA frame buffer and returns a done pulse
`timescale 1ns/1ps
`default_nettype none

module tile_arbiter
	import tile_arb_pkg::*;
#(
	parameter int  NUM_REQ   = DEF_NUM_REQ,
	parameter int  TILE_SIZE = DEF_TILE_SIZE,
	parameter int  SCREEN_W  = DEF_SCREEN_W,
	localparam int IDX_W     = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1
) (
	input  wire logic               clk,
	input  wire logic               arst_n,

	// engine side
	input  wire logic [NUM_REQ-1:0] req,
	input  wire band_t              band,
	input  wire color_t             pxl_clr,
	output logic                    start,
	output logic [NUM_REQ-1:0]      done,

	// SRAM write port
	output pix_addr_t               sram_addr,
	output color_t                  sram_wdata,
	output logic                    sram_wr
);

	logic             req_valid;
	logic [IDX_W-1:0] req_idx;
	logic             tile_end;
	logic [IDX_W-1:0] tile_idx;

	// ------------------------------------------------------------
	// decode, execute, result
	// ------------------------------------------------------------
	tile_req_decode #(
		.NUM_REQ (NUM_REQ)
	) tile_req_decode_inst (
		.req       (req),
		.req_valid (req_valid),
		.req_idx   (req_idx)
	);

	tile_walk_exec #(
		.NUM_REQ   (NUM_REQ),
		.TILE_SIZE (TILE_SIZE),
		.SCREEN_W  (SCREEN_W)
	) tile_walk_exec_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_valid  (req_valid),
		.req_idx    (req_idx),
		.band       (band),
		.pxl_clr    (pxl_clr),
		.start      (start),
		.sram_addr  (sram_addr),
		.sram_wdata (sram_wdata),
		.sram_wr    (sram_wr),
		.tile_end   (tile_end),
		.tile_idx   (tile_idx)
	);

	tile_done_flags #(
		.NUM_REQ (NUM_REQ)
	) tile_done_flags_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.tile_end (tile_end),
		.tile_idx (tile_idx),
		.done     (done)
	);

endmodule

`default_nettype wire

//--- verif/tb_tile_arbiter.sv
// testbench for the tile write arbiter
// directed tests for start pulse, single tile, done pulse, priority
// and address generation over random engines and bands
`timescale 1ns/1ps
`default_nettype none

module tb_tile_arbiter
	import tile_arb_pkg::*;
();

	localparam int          NUM_REQ   = DEF_NUM_REQ;
	localparam int          TILE_SIZE = DEF_TILE_SIZE;
	localparam int          SCREEN_W  = DEF_SCREEN_W;
	localparam int          WAIT_MAX  = 50;  // cycles before a wait gives up
	localparam logic [31:0] SEED      = 32'h753b6136;

	logic               clk;
	logic               arst_n;
	logic [NUM_REQ-1:0] req;
	band_t              band;
	color_t             pxl_clr;
	logic               start;
	logic [NUM_REQ-1:0] done;
	pix_addr_t          sram_addr;
	color_t             sram_wdata;
	logic               sram_wr;

	logic [31:0] clr_state;   // colour stream
	logic [31:0] pick_state;  // engine and band picks
	color_t      last_clr;    // colour the DUT took at the last edge
	int          checks;
	int          errors;

	tile_arbiter tile_arbiter_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.req        (req),
		.band       (band),
		.pxl_clr    (pxl_clr),
		.start      (start),
		.done       (done),
		.sram_addr  (sram_addr),
		.sram_wdata (sram_wdata),
		.sram_wr    (sram_wr)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// fresh colour every cycle
	always @(posedge clk) begin
		last_clr  <= pxl_clr;
		clr_state <= lcg_step(clr_state);
		pxl_clr   <= clr_state[31:24];
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	task automatic check_value(input string name, input string what,
	                           input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("FAILED %s: %s expected 'h%0h, actual 'h%0h", name, what, exp, act);
		end
	endtask

	// screen position of tile origin plus pixel offset
	function automatic pix_addr_t exp_addr(input int idx, input int bnd,
	                                       input int c, input int r);
		int x;
		int y;
		x = idx * TILE_SIZE + c;
		y = bnd * TILE_SIZE + r;
		return pix_addr_t'(y * SCREEN_W + x);
	endfunction

	task automatic raise_req(input int idx, input int bnd);
		@(posedge clk);
		req[idx] <= 1'b1;
		band     <= band_t'(bnd);
	endtask

	// waits for the first write, then checks the whole raster
	task automatic check_writes(input string name, input int idx, input int bnd);
		int n;
		n = 0;
		while (sram_wr !== 1'b1 && n < WAIT_MAX) begin
			@(negedge clk);
			n++;
		end
		if (sram_wr !== 1'b1) begin
			errors++;
			$display("%s: no SRAM write started within %0d cycles", name, WAIT_MAX);
			return;
		end
		for (int r = 0; r < TILE_SIZE; r++) begin
			for (int c = 0; c < TILE_SIZE; c++) begin
				check_value(name, "sram_wr", 1, sram_wr);
				check_value(name, "sram_addr", exp_addr(idx, bnd, c, r), sram_addr);
				check_value(name, "sram_wdata", last_clr, sram_wdata);
				check_value(name, "done", 0, done);
				@(negedge clk);
			end
		end
	endtask

	// called in the cycle right after the last write
	task automatic check_done(input string name, input int idx);
		logic [NUM_REQ-1:0] one_hot;
		one_hot      = '0;
		one_hot[idx] = 1'b1;
		check_value(name, "sram_wr after tile", 0, sram_wr);
		check_value(name, "done", one_hot, done);
		@(posedge clk);
		req[idx] <= 1'b0;  // engine saw its done bit
		@(negedge clk);
		check_value(name, "done after pulse", 0, done);
		check_value(name, "sram_wr in idle", 0, sram_wr);
	endtask

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------
	task automatic test_reset_start();
		repeat (4) begin
			@(negedge clk);
			check_value("reset_start", "sram_wr in reset", 0, sram_wr);
			check_value("reset_start", "done in reset", 0, done);
			check_value("reset_start", "start in reset", 0, start);
		end
		@(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_value("reset_start", "start at release", 0, start);
		@(negedge clk);
		check_value("reset_start", "start pulse", 1, start);
		@(negedge clk);
		check_value("reset_start", "start after pulse", 0, start);
		check_value("reset_start", "sram_wr idle", 0, sram_wr);
		check_value("reset_start", "done idle", 0, done);
	endtask

	task automatic test_single_tile();
		raise_req(5, 0);
		check_writes("single_tile", 5, 0);
	endtask

	task automatic test_done_pulse();
		check_done("done_pulse", 5);
	endtask

	task automatic test_priority();
		@(posedge clk);
		req[40] <= 1'b1;
		req[3]  <= 1'b1;
		req[17] <= 1'b1;
		band    <= band_t'(2);
		check_writes("priority", 3, 2);
		check_done("priority", 3);
		check_writes("priority", 17, 2);
		check_done("priority", 17);
		check_writes("priority", 40, 2);
		check_done("priority", 40);
	endtask

	task automatic test_band_random();
		int eng;
		int bnd;
		for (int i = 0; i < 5; i++) begin
			pick_state = lcg_step(pick_state);
			eng        = (i == 4) ? NUM_REQ - 1 : int'(pick_state[31:16]) % NUM_REQ;
			pick_state = lcg_step(pick_state);
			bnd        = int'(pick_state[31:22]);
			raise_req(eng, bnd);
			check_writes("band_random", eng, bnd);
			check_done("band_random", eng);
		end
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		clk        = 1'b0;
		arst_n     = 1'b0;
		req        = '0;
		band       = '0;
		pxl_clr    = '0;
		last_clr   = '0;
		clr_state  = SEED;
		pick_state = SEED;
		checks     = 0;
		errors     = 0;

		test_reset_start();
		test_single_tile();
		test_done_pulse();
		test_priority();
		test_band_random();

		repeat (2) @(negedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
hw/tile_arb_pkg.sv
hw/tile_req_decode.sv
hw/tile_walk_exec.sv
hw/tile_done_flags.sv
hw/tile_arbiter.sv
verif/tb_tile_arbiter.sv

//--- Bender.yml
package:
  name: tile_arbiter

sources:
  # package first, then the RTL bottom up
  - hw/tile_arb_pkg.sv
  - hw/tile_req_decode.sv
  - hw/tile_walk_exec.sv
  - hw/tile_done_flags.sv
  - hw/tile_arbiter.sv

  - target: test
    files:
      - verif/tb_tile_arbiter.sv
